/* design/arc_mem_pkg.sv */
package arc_mem_pkg;

	// memory bus geometry
	localparam int DATA_W = 32;
	localparam int SEL_W = 4;
	localparam int ADR_W = 24;
	localparam int IDX_W = 8;

	// byte offset bits under the word address
	localparam int ADR_LSB = $clog2(SEL_W);

	// byte distance between two consecutive words
	localparam logic [ADR_W-1:0] WORD_STEP = ADR_W'(SEL_W);

	// clears the byte offset, bus addresses are word aligned
	localparam logic [ADR_W-1:0] WORD_MASK = ~ADR_W'(SEL_W - 1);

	// download indices that carry rom images
	localparam logic [IDX_W-1:0] IDX_ROM_OS = IDX_W'(1);
	localparam logic [IDX_W-1:0] IDX_ROM_EXT = IDX_W'(2);

	function automatic logic is_rom_index(input logic [IDX_W-1:0] idx);
		return (idx == IDX_ROM_OS) || (idx == IDX_ROM_EXT);
	endfunction

endpackage

/* design/spi_loader_rx.sv */
`timescale 1ns/10ps

module spi_loader_rx #(
	parameter logic [arc_mem_pkg::ADR_W-1:0] START_ADDR = '0
) (
	input  logic                            CLOCK_27,
	input  logic                            rst_i,
	input  logic                            spi_sck_i,
	input  logic                            spi_ss_i,
	input  logic                            spi_sdi_i,
	output logic                            downloading_o,
	output logic [arc_mem_pkg::IDX_W-1:0]  index_o,
	output logic                            load_we_o,
	output logic [arc_mem_pkg::ADR_W-1:0]  load_adr_o,
	output logic [arc_mem_pkg::DATA_W-1:0] load_dat_o
);

	logic [1:0] sck_sync;
	logic [1:0] ss_sync;
	logic [1:0] sdi_sync;
	logic       sck_prev;
	logic       ss_prev;
	logic       sck_rise;
	logic       ss_fall;
	logic       ss_rise;
	logic [2:0] bit_cnt;
	logic [6:0] bit_shift;
	logic [7:0] rx_byte;
	logic       byte_done;
	logic       have_index;
	logic [arc_mem_pkg::ADR_LSB-1:0] byte_cnt;

	// two flops per pin, then one more for edge detection
	always_ff @(posedge CLOCK_27) begin
		if (rst_i) begin
			sck_sync <= '0;
			ss_sync <= '1;
			sdi_sync <= '0;
			sck_prev <= 1'b0;
			ss_prev <= 1'b1;
		end else begin
			sck_sync <= {sck_sync[0], spi_sck_i};
			ss_sync <= {ss_sync[0], spi_ss_i};
			sdi_sync <= {sdi_sync[0], spi_sdi_i};
			sck_prev <= sck_sync[1];
			ss_prev <= ss_sync[1];
		end
	end

	assign sck_rise = sck_sync[1] && !sck_prev;
	assign ss_fall = !ss_sync[1] && ss_prev;
	assign ss_rise = ss_sync[1] && !ss_prev;

	// msb first, current bit completes the byte
	assign rx_byte = {bit_shift, sdi_sync[1]};
	assign byte_done = downloading_o && sck_rise && (bit_cnt == 3'd7);

	always_ff @(posedge CLOCK_27) begin
		if (rst_i) begin
			downloading_o <= 1'b0;
			load_we_o <= 1'b0;
			have_index <= 1'b0;
			bit_cnt <= '0;
			byte_cnt <= '0;
			index_o <= '0;
			load_adr_o <= START_ADDR;
		end else begin
			load_we_o <= 1'b0;
			// next word goes one word higher
			if (load_we_o) begin
				load_adr_o <= load_adr_o + arc_mem_pkg::WORD_STEP;
			end
			if (ss_fall) begin
				downloading_o <= 1'b1;
				have_index <= 1'b0;
				bit_cnt <= '0;
				byte_cnt <= '0;
				index_o <= '0;
				load_adr_o <= START_ADDR;
			end else if (ss_rise) begin
				downloading_o <= 1'b0;
				byte_cnt <= '0;
			end else if (downloading_o && sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (byte_done) begin
					if (!have_index) begin
						index_o <= rx_byte;
						have_index <= 1'b1;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
						// last byte of the word
						if (&byte_cnt) begin
							load_we_o <= 1'b1;
						end
					end
				end
			end
		end
	end

	// bit shifter and word assembly
	always_ff @(posedge CLOCK_27) begin
		if (downloading_o && sck_rise) begin
			bit_shift <= rx_byte[6:0];
		end
		if (ss_rise) begin
			// drop a partial word
			load_dat_o <= '0;
		end else if (byte_done && have_index) begin
			// little endian, first byte ends up in the low lane
			load_dat_o <= {rx_byte, load_dat_o[arc_mem_pkg::DATA_W-1:8]};
		end
	end

endmodule

/* design/loader_bus_mux.sv */
`timescale 1ns/10ps

module loader_bus_mux (
	input  logic                            CLOCK_27,
	input  logic                            rst_i,
	input  logic                            downloading_i,
	input  logic [arc_mem_pkg::IDX_W-1:0]  index_i,
	input  logic                            load_we_i,
	input  logic [arc_mem_pkg::ADR_W-1:0]  load_adr_i,
	input  logic [arc_mem_pkg::DATA_W-1:0] load_dat_i,
	input  logic                            core_cyc_i,
	input  logic                            core_stb_i,
	input  logic                            core_we_i,
	input  logic [arc_mem_pkg::SEL_W-1:0]  core_sel_i,
	input  logic [arc_mem_pkg::ADR_W-1:0]  core_adr_i,
	input  logic [arc_mem_pkg::DATA_W-1:0] core_dat_i,
	input  logic                            mem_ack_i,
	input  logic [arc_mem_pkg::DATA_W-1:0] mem_rdat_i,
	output logic [arc_mem_pkg::DATA_W-1:0] core_dat_o,
	output logic                            core_ack_o,
	output logic                            core_rst_o,
	output logic                            mem_cyc_o,
	output logic                            mem_stb_o,
	output logic                            mem_we_o,
	output logic [arc_mem_pkg::SEL_W-1:0]  mem_sel_o,
	output logic [arc_mem_pkg::ADR_W-1:0]  mem_adr_o,
	output logic [arc_mem_pkg::DATA_W-1:0] mem_wdat_o
);

	logic rom_load;
	logic core_req;
	logic ldr_own;
	logic ldr_own_d;
	logic ldr_cyc;
	logic pend_valid;
	logic rom_ready;
	logic [arc_mem_pkg::ADR_W-1:0]  pend_adr;
	logic [arc_mem_pkg::DATA_W-1:0] pend_dat;

	assign rom_load = downloading_i && arc_mem_pkg::is_rom_index(index_i);
	assign core_req = core_cyc_i && core_stb_i;

	always_ff @(posedge CLOCK_27) begin
		if (rst_i) begin
			ldr_own <= 1'b0;
			ldr_own_d <= 1'b0;
			ldr_cyc <= 1'b0;
			pend_valid <= 1'b0;
			rom_ready <= 1'b0;
		end else begin
			ldr_own_d <= ldr_own;
			if (ldr_own_d && !ldr_own) begin
				rom_ready <= 1'b1;
			end
			// one word buffer, non rom words never enter it
			if (load_we_i && rom_load) begin
				pend_valid <= 1'b1;
			end else if (ldr_cyc && mem_ack_i) begin
				pend_valid <= 1'b0;
			end
			if (ldr_cyc) begin
				if (mem_ack_i) begin
					ldr_cyc <= 1'b0;
				end
			end else if (ldr_own && pend_valid) begin
				ldr_cyc <= 1'b1;
			end
			// take the port only between core cycles
			if (!ldr_own) begin
				if ((rom_load || pend_valid) && (!core_req || mem_ack_i)) begin
					ldr_own <= 1'b1;
				end
			end else if (!rom_load && !pend_valid && !ldr_cyc) begin
				ldr_own <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLOCK_27) begin
		if (load_we_i && rom_load) begin
			pend_adr <= load_adr_i;
			pend_dat <= load_dat_i;
		end
	end

	// loader writes are always full words
	assign mem_cyc_o = ldr_own ? ldr_cyc : core_cyc_i;
	assign mem_stb_o = ldr_own ? ldr_cyc : core_stb_i;
	assign mem_we_o = ldr_own ? 1'b1 : core_we_i;
	assign mem_sel_o = ldr_own ? {arc_mem_pkg::SEL_W{1'b1}} : core_sel_i;
	assign mem_adr_o = (ldr_own ? pend_adr : core_adr_i) & arc_mem_pkg::WORD_MASK;
	assign mem_wdat_o = ldr_own ? pend_dat : core_dat_i;

	// core stalls while the loader holds the port
	assign core_dat_o = mem_rdat_i;
	assign core_ack_o = !ldr_own && mem_ack_i;
	assign core_rst_o = !rom_ready;

endmodule

/* design/sram_wb_slave.sv */
`timescale 1ns/10ps

module sram_wb_slave #(
	parameter int MEM_WORDS = 1024,
	parameter int WAIT_CYCLES = 1
) (
	input  logic                            CLOCK_27,
	input  logic                            rst_i,
	input  logic                            cyc_i,
	input  logic                            stb_i,
	input  logic                            we_i,
	input  logic [arc_mem_pkg::SEL_W-1:0]  sel_i,
	input  logic [arc_mem_pkg::ADR_W-1:0]  adr_i,
	input  logic [arc_mem_pkg::DATA_W-1:0] dat_i,
	output logic [arc_mem_pkg::DATA_W-1:0] dat_o,
	output logic                            ack_o
);

	localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

	logic [arc_mem_pkg::DATA_W-1:0] mem [MEM_WORDS];
	logic [AW-1:0]    word_idx;
	logic [CNT_W-1:0] wait_cnt;
	logic             req;
	logic             done;

	// upper address bits dropped, so accesses wrap at the depth
	assign word_idx = adr_i[arc_mem_pkg::ADR_LSB +: AW];
	assign req = cyc_i && stb_i && !ack_o;
	assign done = req && (wait_cnt == CNT_W'(WAIT_CYCLES));

	always_ff @(posedge CLOCK_27) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			wait_cnt <= '0;
		end else begin
			ack_o <= done;
			if (done || !req) begin
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	// access happens on the edge that raises ack
	always_ff @(posedge CLOCK_27) begin
		if (done) begin
			dat_o <= mem[word_idx];
			if (we_i) begin
				for (int b = 0; b < arc_mem_pkg::SEL_W; b++) begin
					if (sel_i[b]) begin
						mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

/* design/arc_mem_top.sv */
`timescale 1ns/10ps

module arc_mem_top #(
	parameter logic [arc_mem_pkg::ADR_W-1:0] START_ADDR = 24'h000000,
	parameter int MEM_WORDS = 1024,
	parameter int WAIT_CYCLES = 1
) (
	input  logic                            CLOCK_27,
	input  logic                            rst_i,
	input  logic                            spi_sck_i,
	input  logic                            spi_ss_i,
	input  logic                            spi_sdi_i,
	input  logic                            core_cyc_i,
	input  logic                            core_stb_i,
	input  logic                            core_we_i,
	input  logic [arc_mem_pkg::SEL_W-1:0]  core_sel_i,
	input  logic [arc_mem_pkg::ADR_W-1:0]  core_adr_i,
	input  logic [arc_mem_pkg::DATA_W-1:0] core_dat_i,
	output logic [arc_mem_pkg::DATA_W-1:0] core_dat_o,
	output logic                            core_ack_o,
	output logic                            core_rst_o
);

	// receiver to mux
	logic                            downloading;
	logic [arc_mem_pkg::IDX_W-1:0]  index;
	logic                            load_we;
	logic [arc_mem_pkg::ADR_W-1:0]  load_adr;
	logic [arc_mem_pkg::DATA_W-1:0] load_dat;

	// mux to memory
	logic                            mem_cyc;
	logic                            mem_stb;
	logic                            mem_we;
	logic [arc_mem_pkg::SEL_W-1:0]  mem_sel;
	logic [arc_mem_pkg::ADR_W-1:0]  mem_adr;
	logic [arc_mem_pkg::DATA_W-1:0] mem_wdat;
	logic [arc_mem_pkg::DATA_W-1:0] mem_rdat;
	logic                            mem_ack;

	spi_loader_rx #(
		.START_ADDR(START_ADDR)
	) i_spi_loader_rx (
		.CLOCK_27     (CLOCK_27),
		.rst_i        (rst_i),
		.spi_sck_i    (spi_sck_i),
		.spi_ss_i     (spi_ss_i),
		.spi_sdi_i    (spi_sdi_i),
		.downloading_o(downloading),
		.index_o      (index),
		.load_we_o    (load_we),
		.load_adr_o   (load_adr),
		.load_dat_o   (load_dat)
	);

	loader_bus_mux i_loader_bus_mux (
		.CLOCK_27     (CLOCK_27),
		.rst_i        (rst_i),
		.downloading_i(downloading),
		.index_i      (index),
		.load_we_i    (load_we),
		.load_adr_i   (load_adr),
		.load_dat_i   (load_dat),
		.core_cyc_i   (core_cyc_i),
		.core_stb_i   (core_stb_i),
		.core_we_i    (core_we_i),
		.core_sel_i   (core_sel_i),
		.core_adr_i   (core_adr_i),
		.core_dat_i   (core_dat_i),
		.mem_ack_i    (mem_ack),
		.mem_rdat_i   (mem_rdat),
		.core_dat_o   (core_dat_o),
		.core_ack_o   (core_ack_o),
		.core_rst_o   (core_rst_o),
		.mem_cyc_o    (mem_cyc),
		.mem_stb_o    (mem_stb),
		.mem_we_o     (mem_we),
		.mem_sel_o    (mem_sel),
		.mem_adr_o    (mem_adr),
		.mem_wdat_o   (mem_wdat)
	);

	sram_wb_slave #(
		.MEM_WORDS  (MEM_WORDS),
		.WAIT_CYCLES(WAIT_CYCLES)
	) i_sram_wb_slave (
		.CLOCK_27(CLOCK_27),
		.rst_i   (rst_i),
		.cyc_i   (mem_cyc),
		.stb_i   (mem_stb),
		.we_i    (mem_we),
		.sel_i   (mem_sel),
		.adr_i   (mem_adr),
		.dat_i   (mem_wdat),
		.dat_o   (mem_rdat),
		.ack_o   (mem_ack)
	);

endmodule

/* verif/arc_mem_tb.sv */
`timescale 1ns/10ps

module arc_mem_tb;

	localparam logic [arc_mem_pkg::ADR_W-1:0] START_ADDR = 24'h000100;
	localparam int MEM_WORDS = 1024;
	localparam int WAIT_CYCLES = 1;
	localparam int MEM_BYTES = MEM_WORDS * arc_mem_pkg::SEL_W;
	// byte address bits that the memory decodes before it wraps
	localparam logic [arc_mem_pkg::ADR_W-1:0] WRAP_MASK = MEM_BYTES - 1;

	// index plus data bytes of the four downloads
	localparam int SPI_BITS = 8 * ((1 + 64) + (1 + 16) + (1 + 18) + (1 + 32));
	localparam int CORE_ACCESSES = 16 + 16 + 2 * 200 + 6 + 1;
	localparam int CYCLE_LIMIT = 2 * (SPI_BITS * 10 + CORE_ACCESSES * (WAIT_CYCLES + 2)) + 2000;

	logic CLOCK_27;
	logic rst;
	logic spi_sck;
	logic spi_ss;
	logic spi_sdi;
	logic core_cyc;
	logic core_stb;
	logic core_we;
	logic [arc_mem_pkg::SEL_W-1:0] core_sel;
	logic [arc_mem_pkg::ADR_W-1:0] core_adr;
	logic [arc_mem_pkg::DATA_W-1:0] core_wdat;
	logic [arc_mem_pkg::DATA_W-1:0] core_rdat;
	logic core_ack;
	logic core_rst;

	// byte-wide model with a written flag per byte
	logic [7:0] model_bytes [MEM_BYTES];
	bit model_known [MEM_BYTES];
	logic [7:0] dl_bytes [64];
	logic [arc_mem_pkg::ADR_W-1:0] written_q [$];
	bit rom_seen = 1'b0;
	// latency varies while the loader holds the port
	bit port_busy = 1'b0;
	int cycle_cnt = 0;
	int unsigned seed_draw;

	arc_mem_top #(
		.START_ADDR (START_ADDR),
		.MEM_WORDS  (MEM_WORDS),
		.WAIT_CYCLES(WAIT_CYCLES)
	) i_arc_mem_top (
		.CLOCK_27  (CLOCK_27),
		.rst_i     (rst),
		.spi_sck_i (spi_sck),
		.spi_ss_i  (spi_ss),
		.spi_sdi_i (spi_sdi),
		.core_cyc_i(core_cyc),
		.core_stb_i(core_stb),
		.core_we_i (core_we),
		.core_sel_i(core_sel),
		.core_adr_i(core_adr),
		.core_dat_i(core_wdat),
		.core_dat_o(core_rdat),
		.core_ack_o(core_ack),
		.core_rst_o(core_rst)
	);

	initial begin
		CLOCK_27 = 1'b0;
		forever #5 CLOCK_27 = ~CLOCK_27;
	end

	always @(posedge CLOCK_27) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "value check");
		end
	endtask

	// once the rom is in, the core stays out of reset
	always @(negedge CLOCK_27) begin
		if (rom_seen) begin
			check_value("core_rst_o", 32'(core_rst), 32'd0);
		end
	end

	// inputs change 1 ns after the rising edge
	task automatic wait_clocks(input int n);
		repeat (n) @(posedge CLOCK_27);
		#1;
	endtask

	function automatic int byte_slot(input logic [arc_mem_pkg::ADR_W-1:0] adr, input int lane);
		return ((adr >> 2) % MEM_WORDS) * arc_mem_pkg::SEL_W + lane;
	endfunction

	function automatic logic [31:0] model_word(input logic [arc_mem_pkg::ADR_W-1:0] adr);
		logic [31:0] w;
		for (int lane = 0; lane < arc_mem_pkg::SEL_W; lane++) begin
			w[8*lane +: 8] = model_bytes[byte_slot(adr, lane)];
		end
		return w;
	endfunction

	function automatic logic [31:0] model_mask(input logic [arc_mem_pkg::ADR_W-1:0] adr);
		logic [31:0] m;
		for (int lane = 0; lane < arc_mem_pkg::SEL_W; lane++) begin
			m[8*lane +: 8] = model_known[byte_slot(adr, lane)] ? 8'hff : 8'h00;
		end
		return m;
	endfunction

	task automatic apply_write(input logic [arc_mem_pkg::ADR_W-1:0] adr,
			input logic [3:0] sel, input logic [31:0] dat);
		for (int lane = 0; lane < arc_mem_pkg::SEL_W; lane++) begin
			if (sel[lane]) begin
				model_bytes[byte_slot(adr, lane)] = dat[8*lane +: 8];
				model_known[byte_slot(adr, lane)] = 1'b1;
			end
		end
	endtask

	// complete words only with the first byte in the low lane
	task automatic load_model_words(input int nbytes);
		for (int w = 0; w < nbytes / 4; w++) begin
			apply_write(START_ADDR + w * 4, 4'hf,
				{dl_bytes[4*w+3], dl_bytes[4*w+2], dl_bytes[4*w+1], dl_bytes[4*w]});
		end
	endtask

	task automatic fill_bytes(input int nbytes);
		for (int i = 0; i < nbytes; i++) begin
			dl_bytes[i] = $urandom % 256;
		end
	endtask

	task automatic send_spi_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_sck = 1'b0;
			spi_sdi = b[i];
			wait_clocks(5);
			spi_sck = 1'b1;
			wait_clocks(5);
		end
	endtask

	task automatic run_download(input logic [7:0] idx, input int nbytes);
		spi_ss = 1'b0;
		wait_clocks(5);
		send_spi_byte(idx);
		for (int i = 0; i < nbytes; i++) begin
			send_spi_byte(dl_bytes[i]);
		end
		spi_sck = 1'b0;
		wait_clocks(5);
		spi_ss = 1'b1;
		wait_clocks(10);
	endtask

	// one classic cycle with ack sampled mid-cycle
	task automatic bus_access(input logic we, input logic [3:0] sel,
			input logic [arc_mem_pkg::ADR_W-1:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int lat;
		lat = 0;
		core_cyc = 1'b1;
		core_stb = 1'b1;
		core_we = we;
		core_sel = sel;
		core_adr = adr;
		core_wdat = wdat;
		@(negedge CLOCK_27);
		while (core_ack !== 1'b1) begin
			lat++;
			@(negedge CLOCK_27);
		end
		rdat = core_rdat;
		// a free port acks a fixed number of cycles after stb
		if (!port_busy) begin
			check_value("core_ack_o latency", lat, WAIT_CYCLES + 1);
		end
		wait_clocks(1);
		// ack lasts a single cycle
		check_value("core_ack_o", 32'(core_ack), 32'd0);
		core_cyc = 1'b0;
		core_stb = 1'b0;
		core_we = 1'b0;
	endtask

	task automatic read_check(input logic [arc_mem_pkg::ADR_W-1:0] adr);
		logic [31:0] rdat;
		bus_access(1'b0, 4'hf, adr, 32'h0, rdat);
		check_value("core_dat_o", rdat & model_mask(adr), model_word(adr) & model_mask(adr));
	endtask

	initial begin
		logic [31:0] rdat;
		logic [arc_mem_pkg::ADR_W-1:0] adr;
		logic [3:0] sel;
		logic [31:0] dat;
		int k;
		seed_draw = $urandom(32'h43a8fb5f);
		rst = 1'b1;
		spi_sck = 1'b0;
		spi_ss = 1'b1;
		spi_sdi = 1'b0;
		core_cyc = 1'b0;
		core_stb = 1'b0;
		core_we = 1'b0;
		core_sel = '0;
		core_adr = '0;
		core_wdat = '0;
		wait_clocks(8);
		rst = 1'b0;

		@(negedge CLOCK_27);
		check_value("core_rst_o", 32'(core_rst), 32'd1);
		check_value("core_ack_o", 32'(core_ack), 32'd0);
		wait_clocks(1);

		// os rom image releases the core
		fill_bytes(64);
		run_download(arc_mem_pkg::IDX_ROM_OS, 64);
		load_model_words(64);
		while (core_rst !== 1'b0) @(negedge CLOCK_27);
		rom_seen = 1'b1;
		wait_clocks(1);
		for (int w = 0; w < 16; w++) begin
			read_check(START_ADDR + w * 4);
		end

		// non rom index leaves memory alone
		fill_bytes(16);
		run_download(8'd5, 16);
		for (int w = 0; w < 16; w++) begin
			read_check(START_ADDR + w * 4);
		end

		// random byte writes with reads aliased through the upper address bits
		for (int i = 0; i < 200; i++) begin
			adr = $urandom & 24'hfffffc;
			sel = $urandom % 16;
			dat = $urandom;
			bus_access(1'b1, sel, adr, dat, rdat);
			apply_write(adr, sel, dat);
			written_q.push_back(adr);
			if ($urandom % 2 == 1) begin
				k = $urandom % written_q.size();
				adr = (written_q[k] & WRAP_MASK) | ($urandom & ~WRAP_MASK);
				read_check(adr);
			end
		end

		// 18 bytes give four words and drop the last two
		fill_bytes(18);
		load_model_words(18);
		run_download(arc_mem_pkg::IDX_ROM_EXT, 18);
		for (int w = 0; w < 6; w++) begin
			read_check(START_ADDR + w * 4);
		end

		// core read stalls behind a running rom load
		fill_bytes(32);
		load_model_words(32);
		fork
			run_download(arc_mem_pkg::IDX_ROM_OS, 32);
			begin
				wait_clocks(300);
				port_busy = 1'b1;
				read_check(START_ADDR + 8);
			end
		join
		wait_clocks(5);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* vlog.f */
design/arc_mem_pkg.sv
design/spi_loader_rx.sv
design/loader_bus_mux.sv
design/sram_wb_slave.sv
design/arc_mem_top.sv
verif/arc_mem_tb.sv

/* Bender.yml */
package:
  name: arc_mem

sources:
  - files:
      - design/arc_mem_pkg.sv
      - design/spi_loader_rx.sv
      - design/loader_bus_mux.sv
      - design/sram_wb_slave.sv
      - design/arc_mem_top.sv
  - target: test
    files:
      - verif/arc_mem_tb.sv
